// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := mc_tb
FILELIST  := mc_system.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)

// File: bench/mc_tb.sv
module mc_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import mc_pkg::*;

   typedef logic [N_CORES-1:0] mask_t;

   // 40 loops x 2 contending cores x ~12 cycles, plus program and data loading, with margin.
   localparam int    MAX_CYCLES = 20000;
   localparam dadr_t OUT_ADR    = 10'h010;
   localparam dadr_t CNT_ADR    = 10'h020;
   localparam data_t ALL_HALTED = data_t'({N_CORES{1'b1}});

   logic    clk = 1'b0;
   logic    reset_n;
   logic    wb_cyc;
   logic    wb_stb;
   logic    wb_we;
   wb_adr_t wb_adr;
   data_t   wb_dat_w;
   data_t   wb_dat_r;
   logic    wb_ack;
   mask_t   halted;
   integer  seed = 32'h6a25_5e2f;
   int      cycles = 0;

   mc_top u_mc_top (
      .clk      (clk),
      .reset_n  (reset_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .halted   (halted)
   );

   always #5 clk = ~clk;

   // ============================================================
   // Reporting and compare tasks
   // ============================================================
   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "Run stopped at the first error.");
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         report_failure($sformatf("Error at %0d ns: %s expected %h, got %h",
                                  $time, name, exp, act));
      end
   endtask

   task automatic check_mask(input string name, input mask_t exp, input mask_t act);
      if (act !== exp) begin
         report_failure($sformatf("Error at %0d ns: %s expected %b, got %b",
                                  $time, name, exp, act));
      end
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         report_failure("Timeout: the test did not finish within the cycle limit.");
      end
   end

   // ============================================================
   // Wishbone host and program builder
   // ============================================================
   task automatic bus_access(input logic we, input wb_adr_t adr, input data_t wdat,
                             output data_t rdat);
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      do begin
         @(negedge clk);
      end while (!wb_ack);                   // Data memory latency varies.
      rdat   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input wb_adr_t adr, input data_t wdat);
      data_t ignored;
      bus_access(1'b1, adr, wdat, ignored);
   endtask

   task automatic wb_read(input wb_adr_t adr, output data_t rdat);
      bus_access(1'b0, adr, '0, rdat);
   endtask

   function automatic wb_adr_t dmem_addr(input dadr_t adr);
      return DMEM_BASE + wb_adr_t'(adr);
   endfunction

   function automatic wb_adr_t imem_addr(input int core_id, input int pc);
      return IMEM_BASE + wb_adr_t'(core_id * IMEM_DEPTH + pc);
   endfunction

   function automatic instr_t encode(input opcode_e op, input logic [1:0] rd,
                                     input logic [1:0] rs, input logic [7:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic instr_t encode_mem(input opcode_e op, input logic [1:0] rd,
                                         input dadr_t adr);
      return {op, rd, adr};
   endfunction

   // Each core adds one to the counter on every pass through its loop.
   function automatic data_t expected_total(input int loops [N_CORES], input data_t init);
      data_t total;
      total = init;
      for (int i = 0; i < N_CORES; i++) begin
         total = total + data_t'(loops[i]);
      end
      return total;
   endfunction

   // ============================================================
   // Run control
   // ============================================================
   task automatic check_after_halt;
      data_t rdat;
      data_t lo_a;
      data_t hi_a;
      data_t lo_b;
      data_t hi_b;
      while (halted !== '1) begin
         @(negedge clk);
      end
      wb_read(REG_STATUS, rdat);
      check_data("REG_STATUS", ALL_HALTED, rdat);
      wb_read(REG_CYC_LO, lo_a);
      wb_read(REG_CYC_HI, hi_a);
      if ({hi_a, lo_a} == 32'd0) begin
         report_failure("The cycle counter is still zero after a run.");
      end
      repeat (20) @(negedge clk);
      check_mask("halted", '1, halted);       // Stays set until run drops.
      wb_read(REG_CYC_LO, lo_b);
      wb_read(REG_CYC_HI, hi_b);
      check_data("REG_CYC_LO", lo_a, lo_b);   // Frozen once all cores halt.
      check_data("REG_CYC_HI", hi_a, hi_b);
   endtask

   task automatic stop_run;
      data_t rdat;
      wb_write(REG_CTRL, 16'h0000);
      @(negedge clk);
      check_mask("halted", '0, halted);
      wb_read(REG_STATUS, rdat);
      check_data("REG_STATUS", 16'h0000, rdat);
   endtask

   // ============================================================
   // Test sequence
   // ============================================================
   initial begin : main
      data_t      rdat;
      dadr_t      wr_adr [8];
      data_t      wr_val [8];
      logic [7:0] out_val [N_CORES];
      int         loops [N_CORES];
      data_t      cnt_init;
      data_t      total;

      reset_n  = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      repeat (16) @(negedge clk);
      reset_n = 1'b1;

      @(negedge clk);
      if (wb_ack !== 1'b0) begin
         report_failure("wb_ack is high right after reset.");
      end
      wb_read(REG_CTRL, rdat);
      check_data("REG_CTRL", 16'h0000, rdat);
      wb_read(REG_STATUS, rdat);
      check_data("REG_STATUS", 16'h0000, rdat);

      for (int i = 0; i < 8; i++) begin
         wr_adr[i] = dadr_t'(10'h100 + i * 16 + ($random(seed) & 15));
         wr_val[i] = data_t'($random(seed));
         wb_write(dmem_addr(wr_adr[i]), wr_val[i]);
      end
      for (int i = 0; i < 8; i++) begin
         wb_read(dmem_addr(wr_adr[i]), rdat);
         check_data($sformatf("dmem[%0h]", wr_adr[i]), wr_val[i], rdat);
      end

      // Low nibble is the core index, so the values stay distinct.
      for (int i = 0; i < N_CORES; i++) begin
         out_val[i] = 8'(($random(seed) & 'hf0) | i);
         wb_write(imem_addr(i, 0), encode(LDI, 2'd0, 2'd0, out_val[i]));
         wb_write(imem_addr(i, 1), encode_mem(ST, 2'd0, OUT_ADR + dadr_t'(i)));
         wb_write(imem_addr(i, 2), encode(HALT, 2'd0, 2'd0, 8'h00));
      end
      wb_write(REG_CTRL, 16'h0001);
      check_after_halt();
      stop_run();
      for (int i = 0; i < N_CORES; i++) begin
         wb_read(dmem_addr(OUT_ADR + dadr_t'(i)), rdat);
         check_data($sformatf("core %0d result", i), {8'h00, out_val[i]}, rdat);
      end

      cnt_init = data_t'($random(seed));
      wb_write(dmem_addr(CNT_ADR), cnt_init);
      for (int i = 0; i < N_CORES; i++) begin
         loops[i] = 1 + (($random(seed) & 32'h7fff_ffff) % 40);
         wb_write(imem_addr(i, 0), encode(LDI, 2'd1, 2'd0, 8'(loops[i])));
         wb_write(imem_addr(i, 1), encode_mem(LOCK, 2'd0, CNT_ADR));
         wb_write(imem_addr(i, 2), encode_mem(LD, 2'd0, CNT_ADR));
         wb_write(imem_addr(i, 3), encode(ADDI, 2'd0, 2'd0, 8'd1));
         wb_write(imem_addr(i, 4), encode_mem(ST, 2'd0, CNT_ADR));
         wb_write(imem_addr(i, 5), encode_mem(UNLOCK, 2'd0, CNT_ADR));
         wb_write(imem_addr(i, 6), encode(ADDI, 2'd1, 2'd0, 8'hff));
         wb_write(imem_addr(i, 7), encode(BNZ, 2'd1, 2'd0, 8'd1));
         wb_write(imem_addr(i, 8), encode(HALT, 2'd0, 2'd0, 8'h00));
      end
      wb_write(REG_CTRL, 16'h0001);
      check_after_halt();

      total = expected_total(loops, cnt_init);
      wb_write(dmem_addr(CNT_ADR), ~total);    // Ignored while the cores run.
      wb_read(dmem_addr(CNT_ADR), rdat);
      check_data("dmem read while running", 16'h0000, rdat);
      stop_run();
      wb_read(dmem_addr(CNT_ADR), rdat);
      check_data("shared counter", total, rdat);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: bench/mc_tb_sva.sv
module mc_tb_sva (
   input logic                     clk,
   input logic                     reset_n,
   input logic                     wb_cyc,
   input logic                     wb_stb,
   input logic                     wb_ack,
   input logic [mc_pkg::N_REQ-1:0] lock_vld,
   input mc_pkg::dadr_t            lock_adr [mc_pkg::N_REQ]
);
   timeunit 1ns;
   timeprecision 1ps;
   import mc_pkg::*;

   logic lock_clash;

   always_comb begin
      lock_clash = 1'b0;
      for (int i = 0; i < N_REQ; i++) begin
         for (int j = i + 1; j < N_REQ; j++) begin
            if (lock_vld[i] && lock_vld[j] && (lock_adr[i] == lock_adr[j])) begin
               lock_clash = 1'b1;
            end
         end
      end
   end

   // ============================================================
   // Wishbone handshake, seen at the falling edge where the host acts
   // ============================================================
   a_ack_in_cycle : assert property (@(negedge clk) disable iff (!reset_n)
      wb_ack |-> (wb_cyc && wb_stb))
      else $error("wb_ack is high outside a bus cycle");

   a_ack_pulse : assert property (@(negedge clk) disable iff (!reset_n)
      wb_ack |=> !wb_ack)
      else $error("wb_ack stays high for two cycles");

   // ============================================================
   // Lock table
   // ============================================================
   a_lock_excl : assert property (@(posedge clk) disable iff (!reset_n)
      !lock_clash)
      else $error("two requesters hold a lock on the same address");

endmodule

// The host_regs bus ports appear unchanged on the top level.
bind mc_top mc_tb_sva u_sva (
   .clk      (clk),
   .reset_n  (reset_n),
   .wb_cyc   (u_host_regs.wb_cyc),
   .wb_stb   (u_host_regs.wb_stb),
   .wb_ack   (u_host_regs.wb_ack),
   .lock_vld (u_shared_mem.lock_vld),
   .lock_adr (u_shared_mem.lock_adr)
);

// File: common/mc_pkg.sv
package mc_pkg;

   // ==========================================================
   // Sizes and widths
   // ==========================================================
   localparam int N_CORES    = 2;
   localparam int N_REQ      = N_CORES + 1;   // Cores first, host last.
   localparam int HOST_ID    = N_REQ - 1;
   localparam int REQ_W      = $clog2(N_REQ);
   localparam int DATA_W     = 16;
   localparam int INSTR_W    = 16;
   localparam int PC_W       = 8;
   localparam int DADR_W     = 10;
   localparam int WB_ADR_W   = 12;
   localparam int IMEM_DEPTH = 1 << PC_W;
   localparam int DMEM_DEPTH = 1 << DADR_W;

   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [INSTR_W-1:0]  instr_t;
   typedef logic [PC_W-1:0]     pc_t;
   typedef logic [DADR_W-1:0]   dadr_t;
   typedef logic [REQ_W-1:0]    req_id_t;
   typedef logic [WB_ADR_W-1:0] wb_adr_t;

   // ==========================================================
   // Instruction set
   // ==========================================================
   // Layout is op[15:12] rd[11:10] rs[9:8] imm[7:0], memory ops use [9:0] as address.
   typedef enum logic [3:0] {
      LDI    = 4'h0,
      ADDI   = 4'h1,
      ADD    = 4'h2,
      LD     = 4'h3,
      ST     = 4'h4,
      LOCK   = 4'h5,
      UNLOCK = 4'h6,
      BNZ    = 4'h7,
      HALT   = 4'hf
   } opcode_e;

   // ==========================================================
   // Host address map
   // ==========================================================
   localparam wb_adr_t IMEM_BASE  = 12'h000;   // Core i sits at i * 256.
   localparam wb_adr_t IMEM_TOP   = IMEM_BASE + wb_adr_t'(N_CORES * IMEM_DEPTH);
   localparam wb_adr_t REG_CTRL   = 12'h200;
   localparam wb_adr_t REG_STATUS = 12'h201;
   localparam wb_adr_t REG_CYC_LO = 12'h202;
   localparam wb_adr_t REG_CYC_HI = 12'h203;
   localparam wb_adr_t DMEM_BASE  = 12'h400;
   localparam wb_adr_t DMEM_TOP   = DMEM_BASE + wb_adr_t'(DMEM_DEPTH);

endpackage

// File: common/mem_if.sv
interface mem_if;
   import mc_pkg::*;

   logic  req;          // Plain read or write.
   logic  we;
   dadr_t adr;          // Data address, or lock address.
   data_t wdat;
   logic  lock_req;
   logic  unlock_req;
   logic  ack;
   data_t rdat;         // Valid in the ack cycle.

   modport master (
      output req,
      output we,
      output adr,
      output wdat,
      output lock_req,
      output unlock_req,
      input  ack,
      input  rdat
   );

   modport slave (
      input  req,
      input  we,
      input  adr,
      input  wdat,
      input  lock_req,
      input  unlock_req,
      output ack,
      output rdat
   );

endinterface

// File: core/core.sv
module core (
   input  logic           clk,
   input  logic           reset_n,
   input  logic           run,
   output mc_pkg::pc_t    imem_adr,
   input  mc_pkg::instr_t imem_dat,
   mem_if.master          mem,
   output logic           halted
);
   import mc_pkg::*;

   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      WAIT_MEM,
      HALTED
   } state_e;

   state_e     state;
   pc_t        pc;
   data_t      rf [4];
   opcode_e    op;
   logic [1:0] rd;
   logic [1:0] rs;
   logic [7:0] imm;
   data_t      imm_sx;
   dadr_t      ea;
   logic       is_mem;

   // ==========================================================
   // Decode
   // ==========================================================
   // The RAM keeps reading pc, so imem_dat stays valid through WAIT_MEM.
   assign op     = opcode_e'(imem_dat[15:12]);
   assign rd     = imem_dat[11:10];
   assign rs     = imem_dat[9:8];
   assign imm    = imem_dat[7:0];
   assign imm_sx = {{(DATA_W-8){imm[7]}}, imm};
   assign ea     = imem_dat[DADR_W-1:0];
   assign is_mem = (op == LD) || (op == ST) || (op == LOCK) || (op == UNLOCK);

   assign imem_adr = pc;
   assign halted   = (state == HALTED);

   // ==========================================================
   // State machine
   // ==========================================================
   always_ff @(posedge clk) begin
      if (!reset_n || !run) begin
         state          <= FETCH;
         pc             <= '0;
         mem.req        <= 1'b0;
         mem.lock_req   <= 1'b0;
         mem.unlock_req <= 1'b0;
         for (int i = 0; i < 4; i++) begin
            rf[i] <= '0;
         end
      end else begin
         case (state)
            FETCH: begin
               state <= EXEC;             // Instruction word arrives next cycle.
            end

            EXEC: begin
               if (is_mem) begin
                  state          <= WAIT_MEM;
                  mem.req        <= (op == LD) || (op == ST);
                  mem.we         <= (op == ST);
                  mem.lock_req   <= (op == LOCK);
                  mem.unlock_req <= (op == UNLOCK);
                  mem.adr        <= ea;
                  mem.wdat       <= rf[rd];
               end else if (op == HALT) begin
                  state <= HALTED;
               end else begin
                  state <= FETCH;
                  pc    <= pc + 1'b1;
                  case (op)
                     LDI:  rf[rd] <= data_t'(imm);
                     ADDI: rf[rd] <= rf[rd] + imm_sx;
                     ADD:  rf[rd] <= rf[rd] + rf[rs];
                     BNZ: begin
                        if (rf[rd] != '0) begin
                           pc <= imm;
                        end
                     end
                     default: ;                 // Unknown opcodes fall through as no-ops.
                  endcase
               end
            end

            WAIT_MEM: begin
               if (mem.ack) begin
                  mem.req        <= 1'b0;
                  mem.lock_req   <= 1'b0;
                  mem.unlock_req <= 1'b0;
                  if (op == LD) begin
                     rf[rd] <= mem.rdat;
                  end
                  pc    <= pc + 1'b1;
                  state <= FETCH;
               end
            end

            HALTED: ;                     // Parked until run drops.

            default: state <= FETCH;
         endcase
      end
   end

endmodule

// File: hdl/host_regs.sv
module host_regs (
   input  logic                        clk,
   input  logic                        reset_n,
   input  logic                        wb_cyc,
   input  logic                        wb_stb,
   input  logic                        wb_we,
   input  mc_pkg::wb_adr_t             wb_adr,
   input  mc_pkg::data_t               wb_dat_w,
   output mc_pkg::data_t               wb_dat_r,
   output logic                        wb_ack,
   output logic [mc_pkg::N_CORES-1:0]  imem_we,
   output mc_pkg::pc_t                 imem_wadr,
   output mc_pkg::instr_t              imem_wdat,
   input  logic [mc_pkg::N_CORES-1:0]  halted,
   output logic                        run,
   mem_if.master                       host
);
   import mc_pkg::*;

   logic [31:0] cyc_cnt;
   logic        start;
   logic        in_imem;
   logic        in_dmem;
   logic        dmem_go;
   data_t       reg_rdat;

   // A new access is taken only outside the ack cycle and the data wait.
   assign start   = wb_cyc & wb_stb & ~wb_ack & ~host.req;
   assign in_imem = (wb_adr >= IMEM_BASE) && (wb_adr < IMEM_TOP);
   assign in_dmem = (wb_adr >= DMEM_BASE) && (wb_adr < DMEM_TOP);
   assign dmem_go = start & in_dmem & ~run;

   // ==========================================================
   // Instruction memory write port
   // ==========================================================
   for (genvar i = 0; i < N_CORES; i++) begin : g_imem_we
      assign imem_we[i] = start & wb_we & in_imem &
                          (wb_adr[WB_ADR_W-1:PC_W] == (WB_ADR_W - PC_W)'(i));
   end

   assign imem_wadr = wb_adr[PC_W-1:0];
   assign imem_wdat = wb_dat_w;

   assign host.lock_req   = 1'b0;
   assign host.unlock_req = 1'b0;

   always_comb begin
      case (wb_adr)
         REG_CTRL:   reg_rdat = data_t'(run);
         REG_STATUS: reg_rdat = data_t'(halted);
         REG_CYC_LO: reg_rdat = cyc_cnt[15:0];
         REG_CYC_HI: reg_rdat = cyc_cnt[31:16];
         default:    reg_rdat = '0;          // Both memories read as zero here.
      endcase
   end

   // ==========================================================
   // Bus cycle, run bit and cycle counter
   // ==========================================================
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         run      <= 1'b0;
         wb_ack   <= 1'b0;
         host.req <= 1'b0;
         cyc_cnt  <= '0;
      end else begin
         wb_ack <= 1'b0;
         if (run && (halted != '1)) begin
            cyc_cnt <= cyc_cnt + 1'b1;
         end
         if (host.req) begin
            if (host.ack) begin
               host.req <= 1'b0;
               wb_ack   <= 1'b1;
               wb_dat_r <= host.rdat;
            end
         end else if (dmem_go) begin
            host.req  <= 1'b1;
            host.we   <= wb_we;
            host.adr  <= wb_adr[DADR_W-1:0];
            host.wdat <= wb_dat_w;
         end else if (start) begin
            wb_ack   <= 1'b1;
            wb_dat_r <= reg_rdat;
            if (wb_we && wb_adr == REG_CTRL) begin
               run <= wb_dat_w[0];
            end
         end
      end
   end

endmodule

// File: hdl/mc_top.sv
module mc_top (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic                       wb_we,
   input  mc_pkg::wb_adr_t            wb_adr,
   input  mc_pkg::data_t              wb_dat_w,
   output mc_pkg::data_t              wb_dat_r,
   output logic                       wb_ack,
   output logic [mc_pkg::N_CORES-1:0] halted
);
   import mc_pkg::*;

   logic               run;
   logic [N_CORES-1:0] imem_we;
   pc_t                imem_wadr;
   instr_t             imem_wdat;
   pc_t                imem_adr [N_CORES];
   instr_t             imem_dat [N_CORES];

   mem_if mif [N_REQ] ();

   // ==========================================================
   // Cores with private instruction memories
   // ==========================================================
   for (genvar i = 0; i < N_CORES; i++) begin : g_core
      word_ram #(
         .elem_t (instr_t),
         .DEPTH  (IMEM_DEPTH)
      ) u_imem (
         .clk  (clk),
         .we   (imem_we[i]),
         .wadr (imem_wadr),
         .wdat (imem_wdat),
         .radr (imem_adr[i]),
         .rdat (imem_dat[i])
      );

      core u_core (
         .clk      (clk),
         .reset_n  (reset_n),
         .run      (run),
         .imem_adr (imem_adr[i]),
         .imem_dat (imem_dat[i]),
         .mem      (mif[i]),
         .halted   (halted[i])
      );
   end

   shared_mem u_shared_mem (
      .clk     (clk),
      .reset_n (reset_n),
      .req     (mif)
   );

   host_regs u_host_regs (
      .clk       (clk),
      .reset_n   (reset_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .imem_we   (imem_we),
      .imem_wadr (imem_wadr),
      .imem_wdat (imem_wdat),
      .halted    (halted),
      .run       (run),
      .host      (mif[HOST_ID])
   );

endmodule

// File: hdl/shared_mem.sv
module shared_mem (
   input logic  clk,
   input logic  reset_n,
   mem_if.slave req [mc_pkg::N_REQ]
);
   import mc_pkg::*;

   logic [N_REQ-1:0] rw_req;
   logic [N_REQ-1:0] wr_en;
   logic [N_REQ-1:0] lk_req;
   logic [N_REQ-1:0] ul_req;
   logic [N_REQ-1:0] pend;
   logic [N_REQ-1:0] conflict;
   logic [N_REQ-1:0] elig;
   logic [N_REQ-1:0] ack_q;
   dadr_t            adr_a [N_REQ];
   data_t            wdat_a [N_REQ];
   dadr_t            lock_adr [N_REQ];
   logic [N_REQ-1:0] lock_vld;
   req_id_t          ptr;
   req_id_t          gnt;
   logic             gnt_vld;
   logic             ram_we;
   data_t            ram_rdat;

   for (genvar i = 0; i < N_REQ; i++) begin : g_req
      assign rw_req[i]   = req[i].req;
      assign wr_en[i]    = req[i].we;
      assign lk_req[i]   = req[i].lock_req;
      assign ul_req[i]   = req[i].unlock_req;
      assign adr_a[i]    = req[i].adr;
      assign wdat_a[i]   = req[i].wdat;
      assign pend[i]     = req[i].req | req[i].lock_req | req[i].unlock_req;
      assign req[i].ack  = ack_q[i];
      assign req[i].rdat = ram_rdat;
   end

   // ==========================================================
   // Arbitration
   // ==========================================================
   always_comb begin
      conflict = '0;
      for (int i = 0; i < N_REQ; i++) begin
         for (int j = 0; j < N_REQ; j++) begin
            if (j != i && lock_vld[j] && lock_adr[j] == adr_a[i]) begin
               conflict[i] = 1'b1;
            end
         end
      end
   end

   // A requester being acked still holds its request, so it sits out one cycle.
   assign elig = pend & ~ack_q & ~(lk_req & conflict);

   // Walk from lowest to highest priority so the last hit wins.
   always_comb begin
      int idx;
      gnt     = '0;
      gnt_vld = 1'b0;
      for (int k = N_REQ - 1; k >= 0; k--) begin
         idx = int'(ptr) + k;
         if (idx >= N_REQ) begin
            idx = idx - N_REQ;
         end
         if (elig[idx]) begin
            gnt     = req_id_t'(idx);
            gnt_vld = 1'b1;
         end
      end
   end

   assign ram_we = gnt_vld & rw_req[gnt] & wr_en[gnt];

   word_ram #(
      .elem_t (data_t),
      .DEPTH  (DMEM_DEPTH)
   ) u_ram (
      .clk  (clk),
      .we   (ram_we),
      .wadr (adr_a[gnt]),
      .wdat (wdat_a[gnt]),
      .radr (adr_a[gnt]),
      .rdat (ram_rdat)
   );

   // ==========================================================
   // Ack, pointer and lock table
   // ==========================================================
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ack_q    <= '0;
         lock_vld <= '0;
         ptr      <= '0;
      end else begin
         ack_q <= '0;
         if (gnt_vld) begin
            ack_q[gnt] <= 1'b1;
            ptr        <= (gnt == req_id_t'(N_REQ - 1)) ? '0 : gnt + 1'b1;
            if (lk_req[gnt]) begin
               lock_vld[gnt] <= 1'b1;
               lock_adr[gnt] <= adr_a[gnt];
            end
            if (ul_req[gnt]) begin
               lock_vld[gnt] <= 1'b0;       // Only the owner's entry is cleared.
            end
         end
      end
   end

endmodule

// File: hdl/word_ram.sv
module word_ram #(
   parameter type elem_t = mc_pkg::data_t,
   parameter int  DEPTH  = mc_pkg::DMEM_DEPTH
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] wadr,
   input  elem_t                    wdat,
   input  logic [$clog2(DEPTH)-1:0] radr,
   output elem_t                    rdat
);

   elem_t ram [DEPTH];

   // Read returns the old word when both ports hit the same address.
   always_ff @(posedge clk) begin
      if (we) begin
         ram[wadr] <= wdat;
      end
      rdat <= ram[radr];
   end

endmodule

// File: mc_system.f
common/mc_pkg.sv
common/mem_if.sv
hdl/word_ram.sv
core/core.sv
hdl/shared_mem.sv
hdl/host_regs.sv
hdl/mc_top.sv
bench/mc_tb_sva.sv
bench/mc_tb.sv
